// ==== rtl/exe_config.svh ====
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

//////////////////////////////////////////////////
// data path and register file

`define EXE_XLEN        32
`define EXE_NREGS       32
`define EXE_REG_AW      5

// stack pointer starts at the top of the data segment
`define EXE_SP_RESET    32'hfffff000
`define EXE_SP_INDEX    29
`define EXE_LINK_INDEX  31              // jal return address

`define EXE_LOAD_LIMIT  28              // loads to 28 and up are discarded

//////////////////////////////////////////////////
// instruction fields

`define EXE_JADDR_W     26              // j/jal target field
`define EXE_BADDR_W     16              // immediate and branch offset

`endif

// ==== rtl/exe_pkg.sv ====
`default_nettype none
`include "exe_config.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]   word_t;
    typedef logic [`EXE_REG_AW-1:0] reg_idx_t;

    //////////////////////////////////////////////////
    // instruction formats

    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    typedef struct packed {
        logic [5:0]              opcode;
        reg_idx_t                rs;
        reg_idx_t                rt;
        logic [`EXE_BADDR_W-1:0] imm;
    } instr_i_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`EXE_JADDR_W-1:0] addr;
    } instr_j_t;

    // same 32 bits, three views
    typedef union packed {
        instr_t   r;
        instr_i_t i;
        instr_j_t j;
    } instr_view_u;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_SLLV = 6'h04,
        F_SRLV = 6'h06,
        F_SRAV = 6'h07,
        F_JR   = 6'h08,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_SLL  = 4'd0,
        ALU_SRL  = 4'd1,
        ALU_SRA  = 4'd2,
        ALU_ADD  = 4'd3,
        ALU_SUB  = 4'd4,
        ALU_AND  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_NOR  = 4'd8,
        ALU_SLT  = 4'd9,
        ALU_SLTU = 4'd10,
        ALU_LUI  = 4'd11,
        ALU_LINK = 4'd12
    } alu_op_e;

    //////////////////////////////////////////////////
    // control and results

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;      // b operand is the immediate
        logic     imm_signed;
        logic     var_shift;    // shift amount from rs
        logic     wb_en;
        reg_idx_t wb_idx;
        logic     is_load;
        logic     is_store;
        logic     is_beq;
        logic     is_bne;
        logic     is_jr;
        logic     is_jump;      // j or jal
        reg_idx_t load_idx;     // target of the pending load
    } ctrl_t;

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } wb_t;

    typedef struct packed {
        word_t addr;
        logic  wen;
        word_t store_data;
    } mem_req_t;

    typedef struct packed {
        logic                    j_valid;
        logic [`EXE_JADDR_W-1:0] j_addr;
        logic                    b_valid;
        logic [`EXE_BADDR_W-1:0] b_addr;
    } redirect_t;

endpackage

`default_nettype wire

// ==== rtl/exe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exe_config.svh"

module exe_ctrl (
    input  wire                  clk_i,
    input  wire                  reset_i,
    input  wire                  exec_en_i,
    input  wire exe_pkg::instr_t instruction_i,
    output exe_pkg::ctrl_t       ctrl_o,
    output logic                 load_pending_o
);

    exe_pkg::ctrl_t    dec;
    exe_pkg::reg_idx_t load_idx_q;
    logic              load_pending_q;
    logic              active;

    assign active = exec_en_i & ~load_pending_q;    // load return owns the write port

    //////////////////////////////////////////////////
    // decode

    always_comb begin
        dec = '0;
        case (instruction_i.opcode)
            exe_pkg::OP_RTYPE: begin
                case (instruction_i.funct)
                    exe_pkg::F_SLL,
                    exe_pkg::F_SLLV: dec.alu_op = exe_pkg::ALU_SLL;
                    exe_pkg::F_SRL,
                    exe_pkg::F_SRLV: dec.alu_op = exe_pkg::ALU_SRL;
                    exe_pkg::F_SRA,
                    exe_pkg::F_SRAV: dec.alu_op = exe_pkg::ALU_SRA;
                    exe_pkg::F_ADD,
                    exe_pkg::F_ADDU: dec.alu_op = exe_pkg::ALU_ADD;     // no overflow trap
                    exe_pkg::F_SUB,
                    exe_pkg::F_SUBU: dec.alu_op = exe_pkg::ALU_SUB;
                    exe_pkg::F_AND:  dec.alu_op = exe_pkg::ALU_AND;
                    exe_pkg::F_OR:   dec.alu_op = exe_pkg::ALU_OR;
                    exe_pkg::F_XOR:  dec.alu_op = exe_pkg::ALU_XOR;
                    exe_pkg::F_NOR:  dec.alu_op = exe_pkg::ALU_NOR;
                    exe_pkg::F_SLT:  dec.alu_op = exe_pkg::ALU_SLT;
                    exe_pkg::F_SLTU: dec.alu_op = exe_pkg::ALU_SLTU;
                    default: ;
                endcase
                dec.is_jr     = instruction_i.funct == exe_pkg::F_JR;
                dec.var_shift = instruction_i.funct inside
                                {exe_pkg::F_SLLV, exe_pkg::F_SRLV, exe_pkg::F_SRAV};
                dec.wb_en     = instruction_i.funct inside
                                {exe_pkg::F_SLL, exe_pkg::F_SRL, exe_pkg::F_SRA,
                                 exe_pkg::F_SLLV, exe_pkg::F_SRLV, exe_pkg::F_SRAV,
                                 exe_pkg::F_ADD, exe_pkg::F_ADDU, exe_pkg::F_SUB,
                                 exe_pkg::F_SUBU, exe_pkg::F_AND, exe_pkg::F_OR,
                                 exe_pkg::F_XOR, exe_pkg::F_NOR, exe_pkg::F_SLT,
                                 exe_pkg::F_SLTU};
                dec.wb_idx    = instruction_i.rd;
            end
            exe_pkg::OP_ADDI: begin
                dec.alu_op     = exe_pkg::ALU_ADD;
                dec.imm_signed = 1'b1;
            end
            exe_pkg::OP_ADDIU: dec.alu_op = exe_pkg::ALU_ADD;  // zero-extended, as before
            exe_pkg::OP_SLTI: begin
                dec.alu_op     = exe_pkg::ALU_SLT;
                dec.imm_signed = 1'b1;
            end
            exe_pkg::OP_SLTIU: begin
                dec.alu_op     = exe_pkg::ALU_SLTU;
                dec.imm_signed = 1'b1;
            end
            exe_pkg::OP_ANDI: dec.alu_op = exe_pkg::ALU_AND;
            exe_pkg::OP_ORI:  dec.alu_op = exe_pkg::ALU_OR;
            exe_pkg::OP_XORI: dec.alu_op = exe_pkg::ALU_XOR;
            exe_pkg::OP_LUI:  dec.alu_op = exe_pkg::ALU_LUI;
            exe_pkg::OP_J:    dec.is_jump = 1'b1;
            exe_pkg::OP_JAL: begin
                dec.is_jump = 1'b1;
                dec.alu_op  = exe_pkg::ALU_LINK;
                dec.wb_en   = 1'b1;
                dec.wb_idx  = exe_pkg::reg_idx_t'(`EXE_LINK_INDEX);
            end
            exe_pkg::OP_BEQ: dec.is_beq = 1'b1;
            exe_pkg::OP_BNE: dec.is_bne = 1'b1;
            exe_pkg::OP_LW:  dec.is_load = 1'b1;
            exe_pkg::OP_SW:  dec.is_store = 1'b1;
            default: ;                                  // unknown, no effect
        endcase

        // immediate arithmetic all write rt
        if (instruction_i.opcode inside {exe_pkg::OP_ADDI, exe_pkg::OP_ADDIU,
                                         exe_pkg::OP_SLTI, exe_pkg::OP_SLTIU,
                                         exe_pkg::OP_ANDI, exe_pkg::OP_ORI,
                                         exe_pkg::OP_XORI, exe_pkg::OP_LUI}) begin
            dec.use_imm = 1'b1;
            dec.wb_en   = 1'b1;
            dec.wb_idx  = instruction_i.rt;
        end
    end

    always_comb begin
        ctrl_o          = active ? dec : '0;
        ctrl_o.load_idx = load_idx_q;
    end

    //////////////////////////////////////////////////
    // load tracking

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            load_pending_q <= 1'b0;
        end else begin
            load_pending_q <= active & dec.is_load;     // one cycle only
        end
    end

    always_ff @(posedge clk_i) begin
        if (active & dec.is_load) begin
            load_idx_q <= instruction_i.rt;
        end
    end

    assign load_pending_o = load_pending_q;

endmodule

`default_nettype wire

// ==== rtl/exe_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exe_config.svh"

module exe_regfile (
    input  wire                    clk_i,
    input  wire                    reset_i,
    input  wire exe_pkg::reg_idx_t rs_idx_i,
    input  wire exe_pkg::reg_idx_t rt_idx_i,
    output exe_pkg::word_t         rs_o,
    output exe_pkg::word_t         rt_o,
    input  wire exe_pkg::wb_t      wb_i,
    input  wire                    load_en_i,
    input  wire exe_pkg::reg_idx_t load_idx_i,
    input  wire exe_pkg::word_t    load_data_i
);

    exe_pkg::word_t regs [`EXE_NREGS];
    logic           load_wr;
    logic           wb_wr;

    // r0 stays zero, high registers are not load targets
    assign load_wr = load_en_i && (load_idx_i != '0) && (load_idx_i < `EXE_LOAD_LIMIT);
    assign wb_wr   = wb_i.en && (wb_i.idx != '0);

    assign rs_o = regs[rs_idx_i];
    assign rt_o = regs[rt_idx_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `EXE_NREGS; i++) begin
                regs[i] <= (i == `EXE_SP_INDEX) ? `EXE_SP_RESET : '0;
            end
        end else if (load_wr) begin
            regs[load_idx_i] <= load_data_i;        // load return wins
        end else if (wb_wr) begin
            regs[wb_i.idx] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exe_alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exe_config.svh"

module exe_alu (
    input  wire exe_pkg::ctrl_t  ctrl_i,
    input  wire exe_pkg::instr_t instruction_i,
    input  wire exe_pkg::word_t  rs_i,
    input  wire exe_pkg::word_t  rt_i,
    input  wire exe_pkg::word_t  pc_plus4_i,
    output exe_pkg::wb_t         wb_o,
    output exe_pkg::word_t       ea_o
);

    exe_pkg::instr_view_u           iv;
    logic [`EXE_BADDR_W-1:0]        imm;
    exe_pkg::word_t                 imm_sx;
    exe_pkg::word_t                 imm_zx;
    exe_pkg::word_t                 op_b;
    logic [$clog2(`EXE_XLEN)-1:0]   shamt;
    exe_pkg::word_t                 sum;
    exe_pkg::word_t                 diff;
    logic                           lt_s;
    logic                           lt_u;
    exe_pkg::word_t                 result;

    assign iv.r = instruction_i;
    assign imm  = iv.i.imm;

    //////////////////////////////////////////////////
    // operands

    assign imm_sx = {{(`EXE_XLEN-`EXE_BADDR_W){imm[`EXE_BADDR_W-1]}}, imm};
    assign imm_zx = {{(`EXE_XLEN-`EXE_BADDR_W){1'b0}}, imm};

    always_comb begin
        if (!ctrl_i.use_imm) begin
            op_b = rt_i;
        end else if (ctrl_i.imm_signed) begin
            op_b = imm_sx;
        end else begin
            op_b = imm_zx;
        end
    end

    // shifts work on rt, amount from shamt or rs
    assign shamt = ctrl_i.var_shift ? rs_i[$bits(shamt)-1:0] : instruction_i.shamt;

    //////////////////////////////////////////////////
    // datapath

    assign sum  = rs_i + op_b;
    assign diff = rs_i - op_b;
    assign lt_s = $signed(rs_i) < $signed(op_b);
    assign lt_u = rs_i < op_b;

    always_comb begin
        case (ctrl_i.alu_op)
            exe_pkg::ALU_SLL:  result = rt_i << shamt;
            exe_pkg::ALU_SRL:  result = rt_i >> shamt;
            exe_pkg::ALU_SRA:  result = exe_pkg::word_t'($signed(rt_i) >>> shamt);
            exe_pkg::ALU_ADD:  result = sum;
            exe_pkg::ALU_SUB:  result = diff;
            exe_pkg::ALU_AND:  result = rs_i & op_b;
            exe_pkg::ALU_OR:   result = rs_i | op_b;
            exe_pkg::ALU_XOR:  result = rs_i ^ op_b;
            exe_pkg::ALU_NOR:  result = ~(rs_i | op_b);
            exe_pkg::ALU_SLT:  result = exe_pkg::word_t'(lt_s);
            exe_pkg::ALU_SLTU: result = exe_pkg::word_t'(lt_u);
            exe_pkg::ALU_LUI:  result = {imm, {(`EXE_XLEN-`EXE_BADDR_W){1'b0}}};
            exe_pkg::ALU_LINK: result = pc_plus4_i;         // jal return address
            default:           result = '0;
        endcase
    end

    assign wb_o = '{en: ctrl_i.wb_en, idx: ctrl_i.wb_idx, data: result};

    // lw/sw address, always sign-extended
    assign ea_o = rs_i + imm_sx;

endmodule

`default_nettype wire

// ==== rtl/exe_redirect.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_redirect (
    input  wire                  clk_i,
    input  wire                  reset_i,
    input  wire exe_pkg::ctrl_t  ctrl_i,
    input  wire exe_pkg::instr_t instruction_i,
    input  wire exe_pkg::word_t  rs_i,
    input  wire exe_pkg::word_t  rt_i,
    output exe_pkg::redirect_t   redirect_o
);

    exe_pkg::instr_view_u iv;
    exe_pkg::redirect_t   redir_q;
    logic                 operands_eq;
    logic                 is_branch;
    logic                 b_taken;
    logic                 is_jmp;

    assign iv.r = instruction_i;

    //////////////////////////////////////////////////
    // branch condition

    assign operands_eq = rs_i == rt_i;
    assign is_branch   = ctrl_i.is_beq | ctrl_i.is_bne;
    assign b_taken     = (ctrl_i.is_beq & operands_eq) | (ctrl_i.is_bne & ~operands_eq);
    assign is_jmp      = ctrl_i.is_jump | ctrl_i.is_jr;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            redir_q <= '0;
        end else begin
            redir_q.j_valid <= is_jmp;              // one-cycle pulses
            redir_q.b_valid <= b_taken;
            if (is_jmp) begin
                redir_q.j_addr <= ctrl_i.is_jr ? rs_i[$bits(redir_q.j_addr)-1:0]
                                               : iv.j.addr;
            end
            if (is_branch) begin
                redir_q.b_addr <= iv.i.imm;         // taken or not
            end
        end
    end

    assign redirect_o = redir_q;

endmodule

`default_nettype wire

// ==== rtl/exe_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exe_config.svh"

module exe_top (
    input  wire                  clk_i,
    input  wire                  reset_i,
    input  wire                  exec_en_i,
    input  wire exe_pkg::instr_t instruction_i,
    input  wire exe_pkg::word_t  pc_plus4_i,
    input  wire exe_pkg::word_t  load_data_i,
    output exe_pkg::mem_req_t    mem_req_o,
    output exe_pkg::redirect_t   redirect_o,
    output logic                 busy_o
);

    exe_pkg::ctrl_t       ctrl;
    logic                 load_pending;
    exe_pkg::word_t       rs_data;
    exe_pkg::word_t       rt_data;
    exe_pkg::wb_t         wb;
    logic [`EXE_XLEN-1:0] ea;
    exe_pkg::mem_req_t    mem_req_q;

    //////////////////////////////////////////////////
    // decode and operands

    exe_ctrl u_ctrl (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .exec_en_i      (exec_en_i),
        .instruction_i  (instruction_i),
        .ctrl_o         (ctrl),
        .load_pending_o (load_pending)
    );

    exe_regfile u_regfile (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .rs_idx_i    (instruction_i.rs),
        .rt_idx_i    (instruction_i.rt),
        .rs_o        (rs_data),
        .rt_o        (rt_data),
        .wb_i        (wb),
        .load_en_i   (load_pending),            // return of last cycle's lw
        .load_idx_i  (ctrl.load_idx),
        .load_data_i (load_data_i)
    );

    //////////////////////////////////////////////////
    // execute

    exe_alu u_alu (
        .ctrl_i        (ctrl),
        .instruction_i (instruction_i),
        .rs_i          (rs_data),
        .rt_i          (rt_data),
        .pc_plus4_i    (pc_plus4_i),
        .wb_o          (wb),
        .ea_o          (ea)
    );

    exe_redirect u_redirect (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .ctrl_i        (ctrl),
        .instruction_i (instruction_i),
        .rs_i          (rs_data),
        .rt_i          (rt_data),
        .redirect_o    (redirect_o)
    );

    //////////////////////////////////////////////////
    // memory request

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_req_q <= '0;
        end else begin
            mem_req_q.wen <= ctrl.is_store;         // pulse for sw
            if (ctrl.is_load | ctrl.is_store) begin
                mem_req_q.addr       <= ea;
                mem_req_q.store_data <= rt_data;    // held until next lw/sw
            end
        end
    end

    assign mem_req_o = mem_req_q;
    assign busy_o    = load_pending;

endmodule

`default_nettype wire

// ==== bench/exe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "exe_config.svh"

module exe_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int WAIT_LIMIT   = 8;

    logic               clk_i = 1'b0;
    logic               reset_i;
    logic               exec_en;
    exe_pkg::instr_t    instruction;
    exe_pkg::word_t     pc_plus4;
    exe_pkg::word_t     load_data;
    exe_pkg::mem_req_t  mem_req;
    exe_pkg::redirect_t redirect;
    logic               busy;

    exe_pkg::word_t     model_regs [`EXE_NREGS];
    logic [31:0]        lfsr_q = 32'h6a70;

    // per-test scratch
    logic [4:0]         rs, rt, rd, sh;
    logic [5:0]         op;
    logic [15:0]        imm;
    logic [25:0]        jaddr;
    logic [31:0]        ins, expected, data, pc;
    logic               taken;
    int                 cycles;

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    exe_top uut (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .exec_en_i     (exec_en),
        .instruction_i (instruction),
        .pc_plus4_i    (pc_plus4),
        .load_data_i   (load_data),
        .mem_req_o     (mem_req),
        .redirect_o    (redirect),
        .busy_o        (busy)
    );

    //////////////////////////////////////////////////
    // stimulus helpers

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] s, input logic [4:0] t,
                                          input logic [4:0] d, input logic [4:0] a,
                                          input logic [5:0] fn);
        return {6'h00, s, t, d, a, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] o, input logic [4:0] s,
                                          input logic [4:0] t, input logic [15:0] k);
        return {o, s, t, k};
    endfunction

    function automatic logic [31:0] sext(input logic [15:0] k);
        return {{16{k[15]}}, k};
    endfunction

    //////////////////////////////////////////////////
    // reference model

    function automatic void write_model(input logic [4:0] idx, input logic [31:0] val);
        if (idx != 5'd0) begin
            model_regs[idx] = val;
        end
    endfunction

    function automatic logic [31:0] imm_model(input logic [5:0] o, input logic [31:0] a,
                                              input logic [15:0] k);
        logic [31:0] zx;
        zx = {16'h0000, k};
        case (o)
            6'h08:   return a + sext(k);
            6'h09:   return a + zx;                 // addiu zero-extends
            6'h0a:   return ($signed(a) < $signed(sext(k))) ? 32'd1 : 32'd0;
            6'h0b:   return (a < sext(k)) ? 32'd1 : 32'd0;
            6'h0c:   return a & zx;
            6'h0d:   return a | zx;
            6'h0e:   return a ^ zx;
            default: return {k, 16'h0000};          // lui
        endcase
    endfunction

    function automatic logic [31:0] rtype_model(input logic [5:0] fn, input logic [31:0] a,
                                                input logic [31:0] b, input logic [4:0] s);
        logic signed [31:0] sb;
        sb = b;
        case (fn)
            6'h00:          return b << s;
            6'h02:          return b >> s;
            6'h03:          return sb >>> s;
            6'h04:          return b << a[4:0];
            6'h06:          return b >> a[4:0];
            6'h07:          return sb >>> a[4:0];
            6'h20, 6'h21:   return a + b;
            6'h22, 6'h23:   return a - b;
            6'h24:          return a & b;
            6'h25:          return a | b;
            6'h26:          return a ^ b;
            6'h27:          return ~(a | b);
            6'h2a:          return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:        return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // drive and check

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    // called on a falling edge, returns on the one after the accepting edge
    task automatic issue(input logic [31:0] word, input logic [31:0] pc_val);
        instruction = word;
        pc_plus4    = pc_val;
        exec_en     = 1'b1;
        @(negedge clk_i);
        exec_en     = 1'b0;
    endtask

    task automatic store_check(input string name, input logic [4:0] base,
                               input logic [15:0] ofs, input logic [4:0] r);
        issue(enc_i(6'h2b, base, r, ofs), 32'd0);
        check_eq({name, " wen"}, 32'd1, 32'(mem_req.wen));
        check_eq({name, " addr"}, model_regs[base] + sext(ofs), mem_req.addr);
        check_eq({name, " data"}, model_regs[r], mem_req.store_data);
        @(negedge clk_i);
        check_eq({name, " wen pulse"}, 32'd0, 32'(mem_req.wen));
    endtask

    task automatic store_random(input string name, input logic [4:0] r);
        logic [4:0]  base;
        logic [15:0] ofs;
        base = 5'(lfsr_bits(5));
        ofs  = 16'(lfsr_bits(16));
        store_check(name, base, ofs, r);
    endtask

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        reset_i     = 1'b1;
        exec_en     = 1'b0;
        instruction = '0;
        pc_plus4    = '0;
        load_data   = '0;
        for (int r = 0; r < `EXE_NREGS; r++) begin
            model_regs[r] = (r == `EXE_SP_INDEX) ? `EXE_SP_RESET : 32'd0;
        end
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;

        check_eq("reset busy", 32'd0, 32'(busy));
        check_eq("reset mem_req", 32'd0, 32'(mem_req.wen) | mem_req.addr | mem_req.store_data);
        check_eq("reset j_valid", 32'd0, 32'(redirect.j_valid));
        check_eq("reset j_addr", 32'd0, 32'(redirect.j_addr));
        check_eq("reset b_valid", 32'd0, 32'(redirect.b_valid));
        check_eq("reset b_addr", 32'd0, 32'(redirect.b_addr));

        // stack register first, then every register
        store_check("reset sp", 5'd0, 16'd0, 5'(`EXE_SP_INDEX));
        for (int r = 0; r < `EXE_NREGS; r++) begin
            store_check("reset regs", 5'd0, 16'd0, 5'(r));
        end

        for (int n = 0; n < 64; n++) begin
            case (3'(lfsr_bits(3)))
                3'd0:    op = 6'h08;
                3'd1:    op = 6'h09;
                3'd2:    op = 6'h0a;
                3'd3:    op = 6'h0b;
                3'd4:    op = 6'h0c;
                3'd5:    op = 6'h0d;
                3'd6:    op = 6'h0e;
                default: op = 6'h0f;
            endcase
            rs  = 5'(lfsr_bits(5));
            rt  = 5'(lfsr_bits(5));
            imm = 16'(lfsr_bits(16));
            expected = imm_model(op, model_regs[rs], imm);
            issue(enc_i(op, rs, rt, imm), 32'd0);
            write_model(rt, expected);
            store_random("imm", rt);
        end

        for (int n = 0; n < 128; n++) begin
            case (4'(lfsr_bits(4)))
                4'd0:    op = 6'h00;
                4'd1:    op = 6'h02;
                4'd2:    op = 6'h03;
                4'd3:    op = 6'h04;
                4'd4:    op = 6'h06;
                4'd5:    op = 6'h07;
                4'd6:    op = 6'h20;
                4'd7:    op = 6'h21;
                4'd8:    op = 6'h22;
                4'd9:    op = 6'h23;
                4'd10:   op = 6'h24;
                4'd11:   op = 6'h25;
                4'd12:   op = 6'h26;
                4'd13:   op = 6'h27;
                4'd14:   op = 6'h2a;
                default: op = 6'h2b;
            endcase
            rs = 5'(lfsr_bits(5));
            rt = 5'(lfsr_bits(5));
            rd = (n % 16 == 0) ? 5'd0 : 5'(lfsr_bits(5));     // some writes aim at r0
            sh = 5'(lfsr_bits(5));
            expected = rtype_model(op, model_regs[rs], model_regs[rt], sh);
            issue(enc_r(rs, rt, rd, sh, op), 32'd0);
            write_model(rd, expected);
            store_random("rtype", rd);
        end
        store_random("r0 zero", 5'd0);

        for (int n = 0; n < 32; n++) begin
            rs   = 5'(lfsr_bits(5));
            rt   = (n % 8 == 0) ? 5'(28 + n / 8) : 5'(lfsr_bits(5));
            imm  = 16'(lfsr_bits(16));
            data = lfsr_bits(32);
            issue(enc_i(6'h23, rs, rt, imm), 32'd0);
            check_eq("lw busy", 32'd1, 32'(busy));
            check_eq("lw addr", model_regs[rs] + sext(imm), mem_req.addr);
            check_eq("lw store_data", model_regs[rt], mem_req.store_data);
            check_eq("lw wen", 32'd0, 32'(mem_req.wen));
            load_data = data;
            cycles    = 0;
            while (busy) begin
                @(negedge clk_i);
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    $display("busy_o stayed high too long after a load");
                    stop_run();
                end
            end
            check_eq("lw busy cycles", 32'd1, cycles);
            if (int'(rt) < `EXE_LOAD_LIMIT) begin
                write_model(rt, data);
            end
            store_random("lw", rt);
        end

        for (int n = 0; n < 32; n++) begin
            rs  = 5'(lfsr_bits(5));
            rt  = (lfsr_bits(1) == 32'd1) ? rs : 5'(lfsr_bits(5));
            op  = (lfsr_bits(1) == 32'd1) ? 6'h04 : 6'h05;
            imm = 16'(lfsr_bits(16));
            taken = (op == 6'h04) ? (model_regs[rs] == model_regs[rt])
                                  : (model_regs[rs] != model_regs[rt]);
            issue(enc_i(op, rs, rt, imm), 32'd0);
            check_eq("branch b_valid", 32'(taken), 32'(redirect.b_valid));
            check_eq("branch b_addr", 32'(imm), 32'(redirect.b_addr));
            check_eq("branch j_valid", 32'd0, 32'(redirect.j_valid));
            @(negedge clk_i);
            check_eq("branch pulse", 32'd0, 32'(redirect.b_valid));
        end

        for (int n = 0; n < 24; n++) begin
            op    = 6'(lfsr_bits(2));                   // 2 j, 3 jal, else jr
            pc    = lfsr_bits(32);
            rs    = 5'(lfsr_bits(5));
            jaddr = 26'(lfsr_bits(26));
            if (op == 6'd2 || op == 6'd3) begin
                ins      = {op, jaddr};
                expected = 32'(jaddr);
            end else begin
                ins      = enc_r(rs, 5'd0, 5'd0, 5'd0, 6'h08);
                expected = 32'(model_regs[rs][25:0]);
            end
            issue(ins, pc);
            check_eq("jump j_valid", 32'd1, 32'(redirect.j_valid));
            check_eq("jump j_addr", expected, 32'(redirect.j_addr));
            @(negedge clk_i);
            check_eq("jump pulse", 32'd0, 32'(redirect.j_valid));
            if (op == 6'd3) begin
                write_model(5'(`EXE_LINK_INDEX), pc);
                store_random("jal link", 5'(`EXE_LINK_INDEX));
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/exe_pkg.sv
rtl/exe_ctrl.sv
rtl/exe_regfile.sv
rtl/exe_alu.sv
rtl/exe_redirect.sv
rtl/exe_top.sv
bench/exe_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module exe_tb -o exe_sim

./obj_dir/exe_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
